// File: Makefile
VERILATOR ?= verilator
TOP ?= tbRenamedRegFile
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timing -j 0
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
renamePkg.sv
regFile.sv
renameTracker.sv
renamedRegFile.sv
renameChecker.sv
tbRenamedRegFile.sv

// File: regFile.sv
`timescale 1ns/1ns

module regFile #(
	parameter int RnDepth = 4,
	localparam int RnBit = $clog2(RnDepth)
) (
	input logic CLK,
	input logic rst,

	// Read ports 0 and 1 are the operands, port 2 is the committed-state read.
	input renamePkg::archIdx_t [2:0] rdIdx,
	input logic [2:0][RnBit-1:0] rdPtr,
	output renamePkg::data_t [2:0] rdData,

	// Two writeback ports.
	input renamePkg::writeBack_t [1:0] wr,
	input logic [1:0][RnBit-1:0] wrPtr
);

	// Total number of copies, register 0 included.
	localparam int NumCopies = renamePkg::NumArchRegs * RnDepth;

	// Copy address is {register index, rename pointer}.
	typedef logic [RnBit+4:0] copyAddr_t;

	// Register 0 owns addresses 0 to RnDepth-1 and has no storage.
	renamePkg::data_t mem [RnDepth:NumCopies-1];

	copyAddr_t rdAddr [3];
	copyAddr_t wrAddr [2];
	logic [1:0] wrFire;

	always_comb begin
		for (int p = 0; p < 3; p++) begin
			rdAddr[p] = {rdIdx[p], rdPtr[p]};
		end
		for (int p = 0; p < 2; p++) begin
			wrAddr[p] = {wr[p].rd, wrPtr[p]};
			// Writes aimed at register 0 are dropped.
			wrFire[p] = wr[p].en && (wr[p].rd != '0);
		end
	end

	// Combinational reads.
	// A write at this edge shows up from the next cycle on.
	always_comb begin
		for (int p = 0; p < 3; p++) begin
			if (rdIdx[p] == '0) begin
				rdData[p] = '0;
			end else begin
				rdData[p] = mem[rdAddr[p]];
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int a = RnDepth; a < NumCopies; a++) begin
				mem[a] <= '0;
			end
		end else begin
			// Port 1 is applied last.
			for (int p = 0; p < 2; p++) begin
				if (wrFire[p]) begin
					mem[wrAddr[p]] <= wr[p].data;
				end
			end
		end
	end

	// Each copy is handed out once per dispatch, so two writebacks
	// in the same cycle always belong to different copies.
	assert property (@(posedge CLK) disable iff (rst)
		(wrFire[0] && wrFire[1]) |-> (wrAddr[0] != wrAddr[1]))
	else
		$error("regFile: both write ports hit copy %0d", wrAddr[0]);

endmodule

// File: renameChecker.sv
`timescale 1ns/1ns

module renameChecker #(
	parameter int RnDepth = 4,
	localparam int RnBit = $clog2(RnDepth)
) (
	input logic CLK,
	input logic rst,
	input renamePkg::dispatchReq_t dispatch,
	input renamePkg::writeBack_t wb0,
	input renamePkg::writeBack_t wb1,
	input logic [RnBit-1:0] wbPtr0,
	input logic [RnBit-1:0] wbPtr1,
	input logic commitEn,
	input renamePkg::archIdx_t commitRd,
	input logic flush,
	input renamePkg::archIdx_t archIdx,
	input logic [RnBit-1:0] rdPtr,
	input logic dispatchStall,
	input renamePkg::data_t rs1Data,
	input logic rs1Ready,
	input renamePkg::data_t rs2Data,
	input logic rs2Ready,
	input renamePkg::data_t archData,
	output int errorCount,
	output int checkCount
);

	typedef logic [RnBit-1:0] ptr_t;

	typedef struct packed {
		ptr_t rdPtr;
		logic stall;
		renamePkg::data_t rs1Data;
		logic rs1Ready;
		renamePkg::data_t rs2Data;
		logic rs2Ready;
		renamePkg::data_t archData;
	} outputs_t;

	// Model of the rings: committed copy, pending count, value and written flag per copy.
	int commitPtr [32];
	int pending [32];
	renamePkg::data_t value [32][RnDepth];
	bit isDone [32][RnDepth];

	// The speculative copy sits pending copies past the committed one.
	function automatic outputs_t expectedOutputs();
		outputs_t e;
		int s1;
		int s2;
		s1 = (commitPtr[dispatch.rs1] + pending[dispatch.rs1]) % RnDepth;
		s2 = (commitPtr[dispatch.rs2] + pending[dispatch.rs2]) % RnDepth;
		e.rdPtr = (dispatch.rd == '0) ? '0
			: ptr_t'((commitPtr[dispatch.rd] + pending[dispatch.rd] + 1) % RnDepth);
		e.stall = dispatch.en && (dispatch.rd != '0) && (pending[dispatch.rd] == RnDepth - 1);
		e.rs1Data = (dispatch.rs1 == '0) ? '0 : value[dispatch.rs1][s1];
		e.rs1Ready = isDone[dispatch.rs1][s1];
		e.rs2Data = (dispatch.rs2 == '0) ? '0 : value[dispatch.rs2][s2];
		e.rs2Ready = isDone[dispatch.rs2][s2];
		e.archData = (archIdx == '0) ? '0 : value[archIdx][commitPtr[archIdx]];
		return e;
	endfunction

	task automatic compareValue(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Fail at %0t ns: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	always @(posedge CLK) begin
		int n;
		if (rst) begin
			foreach (value[r, c]) begin
				value[r][c] = '0;
				isDone[r][c] = (c == 0);
			end
			foreach (commitPtr[r]) begin
				commitPtr[r] = 0;
				pending[r] = 0;
			end
		end else begin
			// Data lands even in a flush cycle.
			if (wb0.en && (wb0.rd != '0)) begin
				value[wb0.rd][wbPtr0] = wb0.data;
				isDone[wb0.rd][wbPtr0] = 1'b1;
			end
			if (wb1.en && (wb1.rd != '0)) begin
				value[wb1.rd][wbPtr1] = wb1.data;
				isDone[wb1.rd][wbPtr1] = 1'b1;
			end
			if (flush) begin
				foreach (isDone[r, c]) begin
					if (c != commitPtr[r]) begin
						isDone[r][c] = 1'b0;
					end
				end
				foreach (pending[r]) begin
					pending[r] = 0;
				end
			end else begin
				if (dispatch.en && (dispatch.rd != '0) && (pending[dispatch.rd] < RnDepth - 1)) begin
					n = (commitPtr[dispatch.rd] + pending[dispatch.rd] + 1) % RnDepth;
					isDone[dispatch.rd][n] = 1'b0;
					pending[dispatch.rd]++;
				end
				if (commitEn && (commitRd != '0)) begin
					isDone[commitRd][commitPtr[commitRd]] = 1'b0;
					commitPtr[commitRd] = (commitPtr[commitRd] + 1) % RnDepth;
					pending[commitRd]--;
				end
			end
		end
	end

	// Outputs are combinational, so mid-cycle they have settled.
	always @(negedge CLK) begin
		outputs_t e;
		if (!rst) begin
			e = expectedOutputs();
			compareValue("rdPtr", 64'(e.rdPtr), 64'(rdPtr));
			compareValue("dispatchStall", 64'(e.stall), 64'(dispatchStall));
			compareValue("rs1Data", e.rs1Data, rs1Data);
			compareValue("rs1Ready", 64'(e.rs1Ready), 64'(rs1Ready));
			compareValue("rs2Data", e.rs2Data, rs2Data);
			compareValue("rs2Ready", 64'(e.rs2Ready), 64'(rs2Ready));
			compareValue("archData", e.archData, archData);
		end
	end

endmodule

// File: renamePkg.sv
package renamePkg;

	// Architectural register count of the integer file.
	localparam int NumArchRegs = 32;

	// Architectural register number.
	typedef logic [4:0] archIdx_t;

	// Register value.
	typedef logic [63:0] data_t;

	// Life cycle of one physical copy.
	// A copy goes free -> pending at dispatch and pending -> done at writeback.
	// Commit of the next copy or a flush returns it to free.
	typedef enum logic [1:0] {
		slotFree,
		slotPending,
		slotDone
	} copyState_t;

	// One dispatch per cycle.
	// Rd gets a fresh copy, and rs1 and rs2 are looked up at the speculative copy.
	typedef struct packed {
		logic en;
		archIdx_t rd;
		archIdx_t rs1;
		archIdx_t rs2;
	} dispatchReq_t;

	// Writeback port.
	// The copy to fill travels next to it as a separate pointer.
	typedef struct packed {
		logic en;
		archIdx_t rd;
		data_t data;
	} writeBack_t;

endpackage

// File: renameTracker.sv
`timescale 1ns/1ns

module renameTracker #(
	parameter int RnDepth = 4,
	localparam int RnBit = $clog2(RnDepth)
) (
	input logic CLK,
	input logic rst,

	input renamePkg::dispatchReq_t dispatch,
	input renamePkg::writeBack_t wb0,
	input renamePkg::writeBack_t wb1,
	input logic [RnBit-1:0] wbPtr0,
	input logic [RnBit-1:0] wbPtr1,
	input logic commitEn,
	input renamePkg::archIdx_t commitRd,
	input logic flush,
	input renamePkg::archIdx_t archIdx,

	output logic [RnBit-1:0] rdPtr,
	output logic dispatchStall,
	output logic [RnBit-1:0] rs1Ptr,
	output logic rs1Ready,
	output logic [RnBit-1:0] rs2Ptr,
	output logic rs2Ready,
	output logic [RnBit-1:0] archPtr
);

	// Rename pointer, also used for the pending count.
	typedef logic [RnBit-1:0] rnPtr_t;

	// Per-register ring bookkeeping.
	// SpecPtr always equals commitPtr + pendCnt modulo RnDepth.
	rnPtr_t specPtr [renamePkg::NumArchRegs];
	rnPtr_t commitPtr [renamePkg::NumArchRegs];
	rnPtr_t pendCnt [renamePkg::NumArchRegs];
	renamePkg::copyState_t copyState [renamePkg::NumArchRegs][RnDepth];

	logic dispatchFire;
	logic commitFire;
	logic wbFire0;
	logic wbFire1;
	rnPtr_t commitNext;

	// Ring full once RnDepth-1 copies wait behind the committed one.
	assign dispatchStall = dispatch.en && (dispatch.rd != '0)
		&& (pendCnt[dispatch.rd] == rnPtr_t'(RnDepth - 1));

	assign dispatchFire = dispatch.en && (dispatch.rd != '0) && !dispatchStall;

	// Register 0 never gets a copy beyond copy 0.
	assign rdPtr = (dispatch.rd == '0) ? '0 : rnPtr_t'(specPtr[dispatch.rd] + 1'b1);

	assign commitFire = commitEn && (commitRd != '0);
	assign commitNext = commitPtr[commitRd] + 1'b1;

	assign wbFire0 = wb0.en && (wb0.rd != '0);
	assign wbFire1 = wb1.en && (wb1.rd != '0);

	// Operand lookup at the speculative copy, before this cycle's dispatch lands.
	assign rs1Ptr = specPtr[dispatch.rs1];
	assign rs2Ptr = specPtr[dispatch.rs2];
	assign rs1Ready = (copyState[dispatch.rs1][rs1Ptr] == renamePkg::slotDone);
	assign rs2Ready = (copyState[dispatch.rs2][rs2Ptr] == renamePkg::slotDone);

	assign archPtr = commitPtr[archIdx];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int r = 0; r < renamePkg::NumArchRegs; r++) begin
				specPtr[r] <= '0;
				commitPtr[r] <= '0;
				pendCnt[r] <= '0;
				// Copy 0 starts as the architectural zero value.
				for (int c = 0; c < RnDepth; c++) begin
					copyState[r][c] <= (c == 0) ? renamePkg::slotDone : renamePkg::slotFree;
				end
			end
		end else if (flush) begin
			// Roll every register back to its committed copy.
			for (int r = 0; r < renamePkg::NumArchRegs; r++) begin
				specPtr[r] <= commitPtr[r];
				pendCnt[r] <= '0;
				for (int c = 0; c < RnDepth; c++) begin
					if (rnPtr_t'(c) != commitPtr[r]) begin
						copyState[r][c] <= renamePkg::slotFree;
					end
				end
			end
		end else begin
			if (wbFire0) begin
				copyState[wb0.rd][wbPtr0] <= renamePkg::slotDone;
			end
			if (wbFire1) begin
				copyState[wb1.rd][wbPtr1] <= renamePkg::slotDone;
			end

			if (dispatchFire) begin
				specPtr[dispatch.rd] <= rdPtr;
				copyState[dispatch.rd][rdPtr] <= renamePkg::slotPending;
			end

			// The old committed copy is released.
			// It never collides with a new allocation since the ring is not full.
			if (commitFire) begin
				commitPtr[commitRd] <= commitNext;
				copyState[commitRd][commitPtr[commitRd]] <= renamePkg::slotFree;
			end

			// Dispatch and commit on the same register leave the count as is.
			if (dispatchFire && !(commitFire && (commitRd == dispatch.rd))) begin
				pendCnt[dispatch.rd] <= pendCnt[dispatch.rd] + 1'b1;
			end
			if (commitFire && !(dispatchFire && (commitRd == dispatch.rd))) begin
				pendCnt[commitRd] <= pendCnt[commitRd] - 1'b1;
			end
		end
	end

	// Writeback only fills a copy handed out at an earlier dispatch.
	assert property (@(posedge CLK) disable iff (rst)
		wbFire0 |-> (copyState[wb0.rd][wbPtr0] == renamePkg::slotPending))
	else
		$error("renameTracker: wb0 to x%0d copy %0d not pending", wb0.rd, wbPtr0);

	assert property (@(posedge CLK) disable iff (rst)
		wbFire1 |-> (copyState[wb1.rd][wbPtr1] == renamePkg::slotPending))
	else
		$error("renameTracker: wb1 to x%0d copy %0d not pending", wb1.rd, wbPtr1);

	// In-order commit needs the next copy written back.
	assert property (@(posedge CLK) disable iff (rst || flush)
		commitFire |-> (copyState[commitRd][commitNext] == renamePkg::slotDone))
	else
		$error("renameTracker: commit of x%0d before writeback", commitRd);

	assert property (@(posedge CLK) disable iff (rst || flush)
		commitFire |-> (pendCnt[commitRd] != '0))
	else
		$error("renameTracker: commit of x%0d with empty ring", commitRd);

endmodule

// File: renamedRegFile.sv
`timescale 1ns/1ns

module renamedRegFile #(
	parameter int RnDepth = 4,
	localparam int RnBit = $clog2(RnDepth)
) (
	input logic CLK,
	input logic rst,

	input renamePkg::dispatchReq_t dispatch,
	input renamePkg::writeBack_t wb0,
	input logic [RnBit-1:0] wbPtr0,
	input renamePkg::writeBack_t wb1,
	input logic [RnBit-1:0] wbPtr1,
	input logic commitEn,
	input renamePkg::archIdx_t commitRd,
	input logic flush,
	input renamePkg::archIdx_t archIdx,

	output logic [RnBit-1:0] rdPtr,
	output logic dispatchStall,
	output renamePkg::data_t rs1Data,
	output logic rs1Ready,
	output renamePkg::data_t rs2Data,
	output logic rs2Ready,
	output renamePkg::data_t archData
);

	logic [RnBit-1:0] rs1Ptr;
	logic [RnBit-1:0] rs2Ptr;
	logic [RnBit-1:0] archPtr;

	// Register file port bundles.
	// Index 0 is rs1, 1 is rs2, 2 is the committed-state read.
	renamePkg::archIdx_t [2:0] readIdx;
	logic [2:0][RnBit-1:0] readPtr;
	renamePkg::data_t [2:0] readData;
	renamePkg::writeBack_t [1:0] wrPort;
	logic [1:0][RnBit-1:0] wrPortPtr;

	assign readIdx[0] = dispatch.rs1;
	assign readIdx[1] = dispatch.rs2;
	assign readIdx[2] = archIdx;
	assign readPtr[0] = rs1Ptr;
	assign readPtr[1] = rs2Ptr;
	assign readPtr[2] = archPtr;

	assign rs1Data = readData[0];
	assign rs2Data = readData[1];
	assign archData = readData[2];

	assign wrPort[0] = wb0;
	assign wrPort[1] = wb1;
	assign wrPortPtr[0] = wbPtr0;
	assign wrPortPtr[1] = wbPtr1;

	renameTracker #(
		.RnDepth(RnDepth)
	) tracker (
		.CLK(CLK),
		.rst(rst),
		.dispatch(dispatch),
		.wb0(wb0),
		.wb1(wb1),
		.wbPtr0(wbPtr0),
		.wbPtr1(wbPtr1),
		.commitEn(commitEn),
		.commitRd(commitRd),
		.flush(flush),
		.archIdx(archIdx),
		.rdPtr(rdPtr),
		.dispatchStall(dispatchStall),
		.rs1Ptr(rs1Ptr),
		.rs1Ready(rs1Ready),
		.rs2Ptr(rs2Ptr),
		.rs2Ready(rs2Ready),
		.archPtr(archPtr)
	);

	regFile #(
		.RnDepth(RnDepth)
	) storage (
		.CLK(CLK),
		.rst(rst),
		.rdIdx(readIdx),
		.rdPtr(readPtr),
		.rdData(readData),
		.wr(wrPort),
		.wrPtr(wrPortPtr)
	);

endmodule

// File: tbRenamedRegFile.sv
`timescale 1ns/1ns

module tbRenamedRegFile;

	localparam int RnDepth = 4;
	localparam int RnBit = $clog2(RnDepth);
	localparam int WaitLimit = 200;

	typedef logic [RnBit-1:0] ptr_t;

	logic CLK;
	logic rst;
	renamePkg::dispatchReq_t dispatch;
	renamePkg::writeBack_t wb0;
	renamePkg::writeBack_t wb1;
	ptr_t wbPtr0;
	ptr_t wbPtr1;
	logic commitEn;
	renamePkg::archIdx_t commitRd;
	logic flush;
	renamePkg::archIdx_t archIdx;
	ptr_t rdPtr;
	logic dispatchStall;
	renamePkg::data_t rs1Data;
	logic rs1Ready;
	renamePkg::data_t rs2Data;
	logic rs2Ready;
	renamePkg::data_t archData;
	int errorCount;
	int checkCount;

	// Copies handed out and not yet written back, as {rd, copy}.
	logic [RnBit+4:0] owed [$];
	int inFlight [32];
	int nextCommit [32];
	bit written [32][RnDepth];
	logic [31:0] lcgState;
	int otherErrors;
	int testBase;
	int testNum;
	int waited;

	renamedRegFile #(.RnDepth(RnDepth)) DUT (.*);
	renameChecker #(.RnDepth(RnDepth)) scoreboard (.*);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState >> 8;
	endfunction

	function automatic int randBelow(int n);
		return int'(nextRand() % n);
	endfunction

	function automatic renamePkg::dispatchReq_t makeDispatch(bit en, int rd, int rs1, int rs2);
		renamePkg::dispatchReq_t d;
		d.en = en;
		d.rd = renamePkg::archIdx_t'(rd);
		d.rs1 = renamePkg::archIdx_t'(rs1);
		d.rs2 = renamePkg::archIdx_t'(rs2);
		return d;
	endfunction

	function automatic int outstanding();
		int n;
		n = owed.size();
		foreach (inFlight[i]) n += inFlight[i];
		return n;
	endfunction

	// With nothing owed the write goes to x0.
	task automatic takeOwed(output renamePkg::writeBack_t w, output ptr_t p);
		logic [RnBit+4:0] entry;
		w.en = 1'b1;
		w.data = {nextRand(), nextRand()};
		if (owed.size() == 0) begin
			w.rd = '0;
			p = ptr_t'(nextRand());
		end else begin
			entry = owed.pop_front();
			w.rd = entry[RnBit+4:RnBit];
			p = entry[RnBit-1:0];
			written[w.rd][p] = 1'b1;
		end
	endtask

	task automatic driveCycle(input renamePkg::dispatchReq_t d, input int wbCount,
			input bit doCommit, input bit doFlush, input int aIdx);
		renamePkg::writeBack_t w0;
		renamePkg::writeBack_t w1;
		ptr_t p0;
		ptr_t p1;
		int start;
		int r;
		bit found;
		w0 = '0;
		w1 = '0;
		p0 = '0;
		p1 = '0;
		found = 1'b0;
		@(posedge CLK);
		dispatch <= d;
		archIdx <= renamePkg::archIdx_t'(aIdx);
		flush <= doFlush;
		commitEn <= 1'b0;
		if (doFlush) begin
			owed.delete();
			foreach (written[i, c]) written[i][c] = 1'b0;
			foreach (inFlight[i]) inFlight[i] = 0;
		end else begin
			// Commit picks the first register whose oldest copy was written back.
			start = randBelow(31);
			for (int i = 0; i < 31; i++) begin
				r = 1 + (start + i) % 31;
				if (doCommit && !found && inFlight[r] > 0 && written[r][nextCommit[r]]) begin
					found = 1'b1;
					commitEn <= 1'b1;
					commitRd <= renamePkg::archIdx_t'(r);
					written[r][nextCommit[r]] = 1'b0;
					nextCommit[r] = (nextCommit[r] + 1) % RnDepth;
					inFlight[r]--;
				end
			end
			if (wbCount > 0) takeOwed(w0, p0);
			if (wbCount > 1) takeOwed(w1, p1);
		end
		wb0 <= w0;
		wbPtr0 <= p0;
		wb1 <= w1;
		wbPtr1 <= p1;
		@(negedge CLK);
		#1;
		if (!flush && dispatch.en && dispatch.rd != '0 && !dispatchStall) begin
			owed.push_back({dispatch.rd, rdPtr});
			inFlight[dispatch.rd]++;
		end
	endtask

	task automatic noteTimeout(input string what);
		otherErrors++;
		$display("Timeout: %s within %0d cycles", what, WaitLimit);
	endtask

	task automatic drainAll(input int aIdx);
		waited = 0;
		while (outstanding() > 0 && waited < WaitLimit) begin
			driveCycle(makeDispatch(1'b0, 0, aIdx, 0), 2, 1'b1, 1'b0, aIdx);
			waited++;
		end
		if (outstanding() > 0) noteTimeout("outstanding copies did not drain");
	endtask

	task automatic finishTest(input string name);
		testNum++;
		$display("Test %0d %s: %0d errors", testNum, name, errorCount + otherErrors - testBase);
		testBase = errorCount + otherErrors;
	endtask

	initial begin
		renamePkg::dispatchReq_t held;
		lcgState = 32'd77;
		rst = 1'b1;
		dispatch = '0;
		wb0 = '0;
		wb1 = '0;
		wbPtr0 = '0;
		wbPtr1 = '0;
		commitEn = 1'b0;
		commitRd = '0;
		flush = 1'b0;
		archIdx = '0;
		foreach (nextCommit[i]) nextCommit[i] = 1;
		for (int i = 0; i < 16; i++) @(posedge CLK);
		rst <= 1'b0;

		for (int i = 0; i < 32; i++) driveCycle(makeDispatch(1'b0, 0, i, 31 - i), 0, 1'b0, 1'b0, i);
		finishTest("reset state");

		driveCycle(makeDispatch(1'b1, 5, 0, 0), 0, 1'b0, 1'b0, 5);
		waited = 0;
		do begin
			driveCycle(makeDispatch(1'b0, 5, 5, 5), 1, 1'b0, 1'b0, 5);
			waited++;
		end while (!rs1Ready && waited < WaitLimit);
		if (!rs1Ready) noteTimeout("x5 never became ready");
		drainAll(5);
		finishTest("dispatch and writeback");

		// Fill the ring of x7, then hold the stalled dispatch across a commit.
		held = makeDispatch(1'b1, 7, 7, 0);
		waited = 0;
		while (!dispatchStall && waited < WaitLimit) begin
			driveCycle(held, 0, 1'b0, 1'b0, 7);
			waited++;
		end
		if (!dispatchStall) begin
			noteTimeout("x7 never stalled");
		end else if (waited != RnDepth) begin
			otherErrors++;
			$display("x7 stalled on dispatch %0d instead of %0d", waited, RnDepth);
		end
		for (int i = 0; i < RnDepth; i++) driveCycle(held, 2, 1'b0, 1'b0, 7);
		driveCycle(held, 0, 1'b1, 1'b0, 7);
		waited = 0;
		while (dispatchStall && waited < WaitLimit) begin
			driveCycle(held, 0, 1'b0, 1'b0, 7);
			waited++;
		end
		if (dispatchStall) noteTimeout("x7 stayed stalled after a commit");
		drainAll(7);
		finishTest("stall and release");

		driveCycle(makeDispatch(1'b1, 9, 0, 0), 0, 1'b0, 1'b0, 9);
		driveCycle(makeDispatch(1'b1, 9, 9, 0), 0, 1'b0, 1'b0, 9);
		drainAll(9);
		finishTest("in-order commit");

		for (int i = 1; i < 8; i++) driveCycle(makeDispatch(1'b1, i, i, 0), i % 3, 1'b1, 1'b0, i);
		driveCycle(makeDispatch(1'b1, 3, 3, 4), 0, 1'b0, 1'b1, 3);
		for (int i = 0; i < 32; i++) driveCycle(makeDispatch(1'b0, 0, i, 31 - i), 0, 1'b0, 1'b0, i);
		driveCycle(makeDispatch(1'b1, 3, 3, 0), 0, 1'b0, 1'b0, 3);
		drainAll(3);
		finishTest("flush");

		for (int i = 0; i < 8; i++) begin
			driveCycle(makeDispatch(1'b1, 0, 0, 0), 2, 1'b0, 1'b0, 0);
			if (dispatchStall) begin
				otherErrors++;
				$display("Dispatch to x0 stalled at %0t ns", $time);
			end
		end
		finishTest("register zero");

		for (int i = 0; i < 400; i++) begin
			held = makeDispatch(randBelow(4) != 0, randBelow(8), randBelow(8), randBelow(8));
			driveCycle(held, randBelow(3), randBelow(2) != 0, randBelow(32) == 0, randBelow(8));
		end
		drainAll(0);
		finishTest("random traffic");

		$display("Summary: %0d compares, %0d value errors, %0d other errors",
			checkCount, errorCount, otherErrors);
		if (errorCount + otherErrors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
